//--- hdl/stm_defines.svh
`ifndef STM_DEFINES_SVH
`define STM_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizes.
`define STM_NUM_SEGMENT  2
`define STM_IDX_W        13
`define STM_REP_W        16
`define STM_TIME_W       64
`define STM_DATA_W       16
`define STM_NUM_GPIO     4

`define STM_DIFF_LATENCY 5                       // Time compare stages.
`define STM_REP_INFINITE {`STM_REP_W{1'b1}}      // Play forever.

`endif

//--- hdl/stm_pattern_mem.sv
`timescale 1ns/100ps
`include "stm_defines.svh"

module stm_pattern_mem (
  input  logic                   CLK,
  input  logic                   reset,
  input  logic                   wr_en,
  input  stm_pkg::segment_t      wr_segment,
  input  logic [`STM_IDX_W-1:0]  wr_addr,
  input  logic [`STM_DATA_W-1:0] wr_data,
  input  stm_pkg::segment_t      segment,
  input  logic [`STM_IDX_W-1:0]  idx [`STM_NUM_SEGMENT],
  input  logic                   stop,
  output logic [`STM_DATA_W-1:0] pattern_data
);

  localparam int AddrW = $bits(stm_pkg::segment_t) + `STM_IDX_W;
  localparam int Depth = `STM_NUM_SEGMENT * (2 ** `STM_IDX_W);

  logic [`STM_DATA_W-1:0] mem [Depth];
  logic [AddrW-1:0]       wr_full;
  logic [AddrW-1:0]       rd_full;

  // Segment selects the bank.
  assign wr_full = {wr_segment, wr_addr};
  assign rd_full = {segment, idx[segment]};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Storage.
  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_full] <= wr_data;
    end
  end

  // Registered read, blanked while stopped.
  always_ff @(posedge CLK) begin
    if (reset) begin
      pattern_data <= '0;
    end else if (stop) begin
      pattern_data <= '0;
    end else begin
      pattern_data <= mem[rd_full];
    end
  end

  // Read address from the swap chain is known while the output is live.
  a_rd_addr_known : assert property (
    @(posedge CLK) disable iff (reset)
    !stop |-> !$isunknown(rd_full)
  );

endmodule

//--- hdl/stm_pkg.sv
package stm_pkg;

  typedef enum logic [7:0] {
    SYNC_IDX = 8'h00,
    SYS_TIME = 8'h01,
    GPIO     = 8'h02,
    EXT      = 8'hF0
  } transition_mode_t;

  typedef enum logic {
    IDX_SYNC,
    IDX_TIC
  } idx_mode_t;

  typedef enum logic [1:0] {
    WAIT_START,
    FINITE_LOOP,
    INFINITE_LOOP
  } swap_state_t;

  typedef logic segment_t;

endpackage

//--- hdl/stm_swapchain.sv
`timescale 1ns/100ps
`include "stm_defines.svh"

module stm_swapchain (
  input  logic                        CLK,
  input  logic                        reset,
  input  logic                        update_settings,
  input  stm_pkg::segment_t           req_segment,
  input  stm_pkg::transition_mode_t   transition_mode,
  input  logic [`STM_TIME_W-1:0]      transition_value,
  input  logic [`STM_IDX_W-1:0]       cycle [`STM_NUM_SEGMENT],
  input  logic [`STM_REP_W-1:0]       rep [`STM_NUM_SEGMENT],
  input  logic [`STM_IDX_W-1:0]       sync_idx [`STM_NUM_SEGMENT],
  input  logic signed [`STM_TIME_W:0] time_diff,
  input  logic [`STM_NUM_GPIO-1:0]    gpio_in,
  output logic                        stop,
  output stm_pkg::segment_t           segment,
  output logic [`STM_IDX_W-1:0]       idx [`STM_NUM_SEGMENT]
);

  localparam int gpio_sel_w = $clog2(`STM_NUM_GPIO);
  localparam int settle_w   = $clog2(`STM_DIFF_LATENCY + 1);
  localparam logic [settle_w-1:0] settle_last = settle_w'(`STM_DIFF_LATENCY - 1);

  stm_pkg::swap_state_t      state;
  stm_pkg::idx_mode_t        idx_mode;
  stm_pkg::transition_mode_t trans_mode;
  stm_pkg::segment_t         req_q;
  logic                      ext_mode;
  logic [gpio_sel_w-1:0]     gpio_sel;
  logic [settle_w-1:0]       settle_cnt;
  logic [`STM_REP_W-1:0]     rep_q;
  logic [`STM_REP_W-1:0]     loop_cnt;
  logic [`STM_IDX_W-1:0]     idx_old [`STM_NUM_SEGMENT];
  logic [`STM_IDX_W-1:0]     tic_idx [`STM_NUM_SEGMENT];
  logic                      idx_changed [`STM_NUM_SEGMENT];
  logic                      idx_wrapped [`STM_NUM_SEGMENT];
  logic                      start_fire;
  logic                      start_tic;
  logic                      tic_wrap;
  logic                      loop_event;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Change and wrap detection on the shared index.
  for (genvar s = 0; s < `STM_NUM_SEGMENT; s++) begin : g_seg
    always_ff @(posedge CLK) begin
      if (reset) begin
        idx_old[s] <= '0;
      end else begin
        idx_old[s] <= sync_idx[s];
      end
    end

    assign idx_changed[s] = idx_old[s] != sync_idx[s];
    assign idx_wrapped[s] = idx_changed[s] && (sync_idx[s] == '0);
    assign idx[s] = (idx_mode == stm_pkg::IDX_SYNC) ? idx_old[s] : tic_idx[s];
  end

  // Start condition of a pending finite request.
  always_comb begin
    start_fire = 1'b0;
    start_tic  = 1'b0;
    case (trans_mode)
      stm_pkg::SYNC_IDX: start_fire = idx_wrapped[req_q];
      stm_pkg::SYS_TIME: begin
        start_fire = (settle_cnt == settle_last) && !time_diff[`STM_TIME_W];
        start_tic  = 1'b1;
      end
      stm_pkg::GPIO: begin
        start_fire = idx_changed[req_q] && gpio_in[gpio_sel];
        start_tic  = 1'b1;
      end
      default: ;
    endcase
  end

  assign tic_wrap   = idx_changed[segment] && (tic_idx[segment] == cycle[segment]);
  assign loop_event = (idx_mode == stm_pkg::IDX_SYNC) ? idx_wrapped[segment] : tic_wrap;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Swap FSM.
  always_ff @(posedge CLK) begin
    if (reset) begin
      state      <= stm_pkg::INFINITE_LOOP;
      idx_mode   <= stm_pkg::IDX_SYNC;
      trans_mode <= stm_pkg::SYNC_IDX;
      segment    <= '0;
      req_q      <= '0;
      stop       <= 1'b0;
      ext_mode   <= 1'b0;
      settle_cnt <= '0;
    end else if (update_settings) begin
      if (rep[req_segment] == `STM_REP_INFINITE) begin
        stop     <= 1'b0;
        segment  <= req_segment;
        idx_mode <= stm_pkg::IDX_SYNC;
        ext_mode <= transition_mode == stm_pkg::EXT;
        state    <= stm_pkg::INFINITE_LOOP;
      end else begin
        rep_q      <= rep[req_segment];
        req_q      <= req_segment;
        trans_mode <= transition_mode;
        gpio_sel   <= transition_value[gpio_sel_w-1:0];
        settle_cnt <= '0;
        state      <= stm_pkg::WAIT_START;
      end
    end else begin
      case (state)
        stm_pkg::WAIT_START: begin
          if (settle_cnt != settle_last) settle_cnt <= settle_cnt + 1'b1; // Compare pipe fill.
          if (start_fire) begin
            stop           <= 1'b0;
            loop_cnt       <= '0;
            segment        <= req_q;
            tic_idx[req_q] <= '0;
            idx_mode       <= start_tic ? stm_pkg::IDX_TIC : stm_pkg::IDX_SYNC;
            state          <= stm_pkg::FINITE_LOOP;
          end
        end
        stm_pkg::INFINITE_LOOP: begin
          if (ext_mode && idx_wrapped[segment]) segment <= ~segment;
        end
        stm_pkg::FINITE_LOOP: begin
          if ((idx_mode == stm_pkg::IDX_TIC) && idx_changed[segment]) begin
            tic_idx[segment] <= tic_wrap ? '0 : tic_idx[segment] + 1'b1;
          end
          if (loop_event) begin
            if (loop_cnt == rep_q) begin
              stop <= 1'b1;                     // Last loop done.
            end else begin
              loop_cnt <= loop_cnt + 1'b1;
            end
          end
        end
        default: state <= stm_pkg::INFINITE_LOOP;
      endcase
    end
  end

  a_single_update : assert property (
    @(posedge CLK) disable iff (reset)
    update_settings |=> !update_settings
  );

  a_no_stop_infinite : assert property (
    @(posedge CLK) disable iff (reset)
    (state == stm_pkg::INFINITE_LOOP) |-> !stop
  );

endmodule

//--- hdl/stm_top.sv
`timescale 1ns/100ps
`include "stm_defines.svh"

module stm_top (
  input  logic                      CLK,
  input  logic                      reset,
  input  logic [`STM_IDX_W-1:0]     cycle [`STM_NUM_SEGMENT],
  input  logic [`STM_REP_W-1:0]     rep [`STM_NUM_SEGMENT],
  input  stm_pkg::transition_mode_t transition_mode,
  input  logic [`STM_TIME_W-1:0]    transition_value,
  input  logic                      update_settings,
  input  stm_pkg::segment_t         req_segment,
  input  logic                      sync_tick,
  input  logic [`STM_TIME_W-1:0]    sys_time,
  input  logic [`STM_NUM_GPIO-1:0]  gpio_in,
  input  logic                      wr_en,
  input  stm_pkg::segment_t         wr_segment,
  input  logic [`STM_IDX_W-1:0]     wr_addr,
  input  logic [`STM_DATA_W-1:0]    wr_data,
  output logic                      stop,
  output stm_pkg::segment_t         segment,
  output logic [`STM_IDX_W-1:0]     idx [`STM_NUM_SEGMENT],
  output logic [`STM_DATA_W-1:0]    pattern_data
);

  logic [`STM_IDX_W-1:0]      sync_idx [`STM_NUM_SEGMENT];
  logic signed [`STM_TIME_W:0] time_diff;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Input side.
  sync_idx_counter u_sync_idx_counter (
    .CLK      (CLK),
    .reset    (reset),
    .sync_tick(sync_tick),
    .cycle    (cycle),
    .sync_idx (sync_idx)
  );

  time_diff_pipe u_time_diff_pipe (
    .CLK             (CLK),
    .reset           (reset),
    .sys_time        (sys_time),
    .transition_value(transition_value),
    .time_diff       (time_diff)
  );

  // Segment selection.
  stm_swapchain u_stm_swapchain (
    .CLK             (CLK),
    .reset           (reset),
    .update_settings (update_settings),
    .req_segment     (req_segment),
    .transition_mode (transition_mode),
    .transition_value(transition_value),
    .cycle           (cycle),
    .rep             (rep),
    .sync_idx        (sync_idx),
    .time_diff       (time_diff),
    .gpio_in         (gpio_in),
    .stop            (stop),
    .segment         (segment),
    .idx             (idx)
  );

  // Output side.
  stm_pattern_mem u_stm_pattern_mem (
    .CLK         (CLK),
    .reset       (reset),
    .wr_en       (wr_en),
    .wr_segment  (wr_segment),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .segment     (segment),
    .idx         (idx),
    .stop        (stop),
    .pattern_data(pattern_data)
  );

endmodule

//--- hdl/sync_idx_counter.sv
`timescale 1ns/100ps
`include "stm_defines.svh"

module sync_idx_counter (
  input  logic                 CLK,
  input  logic                 reset,
  input  logic                 sync_tick,
  input  logic [`STM_IDX_W-1:0] cycle [`STM_NUM_SEGMENT],
  output logic [`STM_IDX_W-1:0] sync_idx [`STM_NUM_SEGMENT]
);

  logic [`STM_IDX_W-1:0] idx_next [`STM_NUM_SEGMENT];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // One free running index per segment.
  for (genvar s = 0; s < `STM_NUM_SEGMENT; s++) begin : g_seg

    // Wrap also catches a cycle that shrank below the index.
    always_comb begin
      if (sync_idx[s] >= cycle[s]) begin
        idx_next[s] = '0;
      end else begin
        idx_next[s] = sync_idx[s] + 1'b1;
      end
    end

    always_ff @(posedge CLK) begin
      if (reset) begin
        sync_idx[s] <= '0;
      end else if (sync_tick) begin
        sync_idx[s] <= idx_next[s];
      end
    end

    // Index never beyond its cycle value.
    a_idx_in_cycle : assert property (
      @(posedge CLK) disable iff (reset)
      sync_idx[s] <= cycle[s]
    );

  end

endmodule

//--- hdl/time_diff_pipe.sv
`timescale 1ns/100ps
`include "stm_defines.svh"

module time_diff_pipe (
  input  logic                        CLK,
  input  logic                        reset,
  input  logic [`STM_TIME_W-1:0]      sys_time,
  input  logic [`STM_TIME_W-1:0]      transition_value,
  output logic signed [`STM_TIME_W:0] time_diff
);

  localparam int Lat = `STM_DIFF_LATENCY;
  localparam int W   = `STM_TIME_W + 1;
  localparam int CW  = (W + Lat - 1) / Lat;      // Bits per stage.
  localparam int PW  = CW * Lat;

  logic [PW-1:0] a_in;
  logic [PW-1:0] b_in;
  logic [PW-1:0] a_q [Lat];
  logic [PW-1:0] b_q [Lat];
  logic [PW-1:0] r_q [Lat];
  logic          c_q [Lat];

  assign a_in = PW'(sys_time);
  assign b_in = ~PW'(transition_value);           // Plus carry-in of 1 below.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // One chunk per stage, carry passed down the chain.
  for (genvar s = 0; s < Lat; s++) begin : g_stage
    logic [PW-1:0] a_src;
    logic [PW-1:0] b_src;
    logic [PW-1:0] r_src;
    logic          c_src;
    logic [CW:0]   part;

    if (s == 0) begin : g_first
      assign a_src = a_in;
      assign b_src = b_in;
      assign r_src = '0;
      assign c_src = 1'b1;
    end else begin : g_chain
      assign a_src = a_q[s-1];
      assign b_src = b_q[s-1];
      assign r_src = r_q[s-1];
      assign c_src = c_q[s-1];
    end

    assign part = {1'b0, a_src[s*CW +: CW]} + {1'b0, b_src[s*CW +: CW]}
                + {{CW{1'b0}}, c_src};

    always_ff @(posedge CLK) begin
      a_q[s] <= a_src;
      b_q[s] <= b_src;
    end

    always_ff @(posedge CLK) begin
      if (reset) begin
        r_q[s] <= '0;
        c_q[s] <= 1'b0;
      end else begin
        r_q[s]             <= r_src;
        r_q[s][s*CW +: CW] <= part[CW-1:0];
        c_q[s]             <= part[CW];
      end
    end
  end

  assign time_diff = signed'(r_q[Lat-1][W-1:0]);  // Sign set means not reached.

endmodule

//--- list.f
+incdir+hdl
hdl/stm_pkg.sv
hdl/sync_idx_counter.sv
hdl/time_diff_pipe.sv
hdl/stm_swapchain.sv
hdl/stm_pattern_mem.sv
hdl/stm_top.sv
verif/tb_stm.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass line.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f list.f --top-module tb_stm -o sim_stm &&
  ./obj_dir/sim_stm > sim.log 2>&1 ||
  echo "Build or simulation returned an error."

cat sim.log 2>/dev/null
grep -qx "Verification passed" sim.log || exit 1
exit 0

//--- verif/tb_stm.sv
`timescale 1ns/100ps
`include "stm_defines.svh"

module tb_stm;

  localparam int load_cyc     = `STM_NUM_SEGMENT * 16;
  localparam int tick_total   = 20 + 40 + 14 + 29 + 30;
  localparam int run_cyc      = 5 * (load_cyc + 2) + 3 * tick_total + 20 + 10 + 10;
  localparam int watchdog_cyc = 2 * run_cyc + 100;

  logic                      CLK = 1'b0;
  logic                      reset;
  logic [`STM_IDX_W-1:0]     cycle [`STM_NUM_SEGMENT];
  logic [`STM_REP_W-1:0]     rep [`STM_NUM_SEGMENT];
  stm_pkg::transition_mode_t transition_mode;
  logic [`STM_TIME_W-1:0]    transition_value;
  logic                      update_settings;
  stm_pkg::segment_t         req_segment;
  logic                      sync_tick;
  logic [`STM_TIME_W-1:0]    sys_time;
  logic [`STM_NUM_GPIO-1:0]  gpio_in;
  logic                      wr_en;
  stm_pkg::segment_t         wr_segment;
  logic [`STM_IDX_W-1:0]     wr_addr;
  logic [`STM_DATA_W-1:0]    wr_data;
  logic                      stop;
  stm_pkg::segment_t         segment;
  logic [`STM_IDX_W-1:0]     idx [`STM_NUM_SEGMENT];
  logic [`STM_DATA_W-1:0]    pattern_data;

  int                        seed;
  int                        errors;
  string                     test_name;
  logic [`STM_DATA_W-1:0]    model_mem [`STM_NUM_SEGMENT][16];
  logic [`STM_IDX_W-1:0]     model_idx [`STM_NUM_SEGMENT];

  always #10 CLK = ~CLK;

  stm_top u_stm_top (
    .CLK             (CLK),
    .reset           (reset),
    .cycle           (cycle),
    .rep             (rep),
    .transition_mode (transition_mode),
    .transition_value(transition_value),
    .update_settings (update_settings),
    .req_segment     (req_segment),
    .sync_tick       (sync_tick),
    .sys_time        (sys_time),
    .gpio_in         (gpio_in),
    .wr_en           (wr_en),
    .wr_segment      (wr_segment),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .stop            (stop),
    .segment         (segment),
    .idx             (idx),
    .pattern_data    (pattern_data)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Compare tasks.
  task automatic compare_segment(string what, stm_pkg::segment_t expected,
                                 stm_pkg::segment_t actual);
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
    end
  endtask

  task automatic compare_data(string what, logic [`STM_DATA_W-1:0] expected,
                              logic [`STM_DATA_W-1:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %s: %s expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic compare_flag(string what, bit expected, logic actual);
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %s: %s expected %0b, actual %0b", test_name, what, expected, actual);
    end
  endtask

  task automatic compare_index(string what, logic [`STM_IDX_W-1:0] expected,
                               logic [`STM_IDX_W-1:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus helpers.
  task automatic wait_cycle();
    @(posedge CLK);
    #2;
  endtask

  function automatic logic [`STM_IDX_W-1:0] next_tic(logic [`STM_IDX_W-1:0] t,
                                                     logic [`STM_IDX_W-1:0] c);
    return (t == c) ? '0 : t + 1'b1;                 // Wraps after reaching cycle.
  endfunction

  task automatic load_patterns();
    int rnd;
    for (int s = 0; s < `STM_NUM_SEGMENT; s++) begin
      for (int a = 0; a < 16; a++) begin
        rnd = $random(seed);
        wr_en = 1'b1;
        wr_segment = s[0];
        wr_addr = a[`STM_IDX_W-1:0];
        wr_data = rnd[`STM_DATA_W-1:0];
        model_mem[s][a] = rnd[`STM_DATA_W-1:0];
        wait_cycle();
      end
    end
    wr_en = 1'b0;
  endtask

  task automatic pulse_update();
    update_settings = 1'b1;
    wait_cycle();
    update_settings = 1'b0;
  endtask

  // One sync tick with the index model stepped alongside.
  task automatic tick_index();
    sync_tick = 1'b1;
    wait_cycle();
    sync_tick = 1'b0;
    for (int s = 0; s < `STM_NUM_SEGMENT; s++) begin
      model_idx[s] = (model_idx[s] == cycle[s]) ? '0 : model_idx[s] + 1'b1;
    end
  endtask

  task automatic check_after_tick(stm_pkg::segment_t expected_seg, bit expected_stop,
                                  logic [`STM_IDX_W-1:0] expected_idx);
    logic [`STM_DATA_W-1:0] exp_data;
    wait_cycle();
    compare_segment("segment", expected_seg, segment);
    compare_flag("stop", expected_stop, stop);
    if (!expected_stop) compare_index("index", expected_idx, idx[expected_seg]);
    wait_cycle();
    exp_data = expected_stop ? '0 : model_mem[expected_seg][expected_idx[3:0]];
    compare_data("pattern_data", exp_data, pattern_data);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Directed tests.
  task automatic infinite_request();
    test_name = "infinite_request";
    load_patterns();
    rep[0] = `STM_REP_INFINITE;
    rep[1] = `STM_REP_INFINITE;
    transition_mode = stm_pkg::SYNC_IDX;
    req_segment = 1'b1;
    pulse_update();
    compare_segment("segment after strobe", 1'b1, segment);
    compare_flag("stop after strobe", 1'b0, stop);
    repeat (20) begin
      tick_index();
      check_after_tick(1'b1, 1'b0, model_idx[1]);
    end
  endtask

  task automatic sync_wrap_transition();
    stm_pkg::segment_t seg;
    int                wraps;
    bit                started;
    test_name = "sync_wrap_transition";
    load_patterns();
    rep[0] = 16'd2;
    transition_mode = stm_pkg::SYNC_IDX;
    req_segment = 1'b0;
    pulse_update();
    seg = 1'b1;
    wraps = 0;
    started = 1'b0;
    repeat (40) begin
      tick_index();
      if (model_idx[0] == '0) begin
        if (started) wraps++;
        started = 1'b1;                              // Switch on the first wrap.
        seg = 1'b0;
      end
      check_after_tick(seg, wraps >= 3, model_idx[seg]);
    end
    compare_flag("stop at end", 1'b1, stop);
  endtask

  task automatic time_transition();
    int                    waited;
    int                    wraps;
    logic [`STM_IDX_W-1:0] t;
    test_name = "time_transition";
    load_patterns();
    rep[1] = 16'd1;
    transition_mode = stm_pkg::SYS_TIME;
    transition_value = 64'd1000;
    sys_time = 64'd500;
    req_segment = 1'b1;
    pulse_update();
    repeat (20) begin
      wait_cycle();
      compare_segment("segment before time", 1'b0, segment);
    end
    sys_time = 64'd1200;
    waited = 0;
    while (segment !== 1'b1 && waited < `STM_DIFF_LATENCY + 2) begin
      wait_cycle();
      waited++;
    end
    compare_segment("segment after time", 1'b1, segment);
    compare_index("tic index at start", '0, idx[1]);
    compare_flag("stop at start", 1'b0, stop);
    t = '0;
    wraps = 0;
    repeat (14) begin
      tick_index();
      t = next_tic(t, cycle[1]);
      if (t == '0) wraps++;
      check_after_tick(1'b1, wraps >= 2, t);
    end
  endtask

  task automatic gpio_transition();
    int                    wraps;
    logic [`STM_IDX_W-1:0] t;
    test_name = "gpio_transition";
    load_patterns();
    rep[0] = 16'd0;
    transition_mode = stm_pkg::GPIO;
    transition_value = 64'd2;                       // Selects gpio_in[2].
    gpio_in = '0;
    req_segment = 1'b0;
    pulse_update();
    repeat (18) begin
      tick_index();
      check_after_tick(1'b1, 1'b1, '0);
    end
    gpio_in[2] = 1'b1;
    tick_index();
    t = '0;
    check_after_tick(1'b0, 1'b0, t);
    wraps = 0;
    repeat (10) begin
      tick_index();
      t = next_tic(t, cycle[0]);
      if (t == '0) wraps++;
      check_after_tick(1'b0, wraps >= 1, t);
    end
    gpio_in = '0;
  endtask

  task automatic external_flip();
    stm_pkg::segment_t seg;
    test_name = "external_flip";
    load_patterns();
    rep[1] = `STM_REP_INFINITE;
    transition_mode = stm_pkg::EXT;
    req_segment = 1'b1;
    pulse_update();
    compare_segment("segment after strobe", 1'b1, segment);
    compare_flag("stop after strobe", 1'b0, stop);
    seg = 1'b1;
    repeat (30) begin
      tick_index();
      if (model_idx[seg] == '0) seg = !seg;          // Flip on wrap of the active one.
      check_after_tick(seg, 1'b0, model_idx[seg]);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    seed = 78594;
    errors = 0;
    test_name = "reset";
    reset = 1'b1;
    cycle[0] = 13'd7;
    cycle[1] = 13'd5;
    rep[0] = `STM_REP_INFINITE;
    rep[1] = `STM_REP_INFINITE;
    transition_mode = stm_pkg::SYNC_IDX;
    transition_value = '0;
    update_settings = 1'b0;
    req_segment = 1'b0;
    sync_tick = 1'b0;
    sys_time = '0;
    gpio_in = '0;
    wr_en = 1'b0;
    wr_segment = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    model_idx[0] = '0;
    model_idx[1] = '0;
    repeat (4) wait_cycle();
    reset = 1'b0;
    wait_cycle();
    infinite_request();
    sync_wrap_transition();
    time_transition();
    gpio_transition();
    external_flip();
    $display("Checks finished with %0d errors.", errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Watchdog.
  initial begin
    repeat (watchdog_cyc) @(posedge CLK);
    $display("Timeout after %0d cycles, the tests did not finish.", watchdog_cyc);
    $display("Verification failed");
    $finish;
  end

endmodule
